/* flist.f */
source/soc_pkg.sv
source/addr_decode.sv
source/memory_mapper.sv
source/irq_ctrl.sv
source/uart_tx_fifo.sv
source/uart_tx.sv
source/bus_soc.sv
sim/bus_soc_chk.sv
sim/bus_soc_tb.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --assert --top-module bus_soc_tb -f flist.f -o bus_soc_sim || exit 1
out=$(./obj_dir/bus_soc_sim)
echo "$out"
echo "$out" | grep -qx "Finished with no errors" && echo "PASS" || { echo "FAIL"; exit 1; }

/* sim/bus_soc_chk.sv */
`timescale 1ns/1ns

module bus_soc_chk
    import soc_pkg::*;
(
    input logic               clk,
    input logic               rst,
    input logic [15:0]        addr,
    input logic [phys_aw-1:0] phys_addr,
    input logic [7:0]         irq_flags,
    input logic               irqb,
    input logic               txd,
    input tx_state_t          tx_state,
    input logic               fifo_push,
    input logic               fifo_full,
    input logic [fifo_aw-1:0] fifo_wr_ptr
);

    a_irqb_nor: assert property (@(posedge clk) disable iff (rst) irqb == ~|irq_flags)
        else $error("irqb differs from the NOR of the interrupt flags");

    a_idle_txd: assert property (@(posedge clk) disable iff (rst) tx_state == tx_idle |-> txd)
        else $error("txd is low while the serializer is idle");

    // a dropped write must leave the FIFO untouched
    a_full_push: assert property (@(posedge clk) disable iff (rst)
        fifo_push && fifo_full |=> $stable(fifo_wr_ptr))
        else $error("FIFO write pointer moved on a push while full");

    a_page_offset: assert property (@(posedge clk) disable iff (rst)
        phys_addr[11:0] == addr[11:0])
        else $error("phys_addr offset differs from the CPU address");

endmodule

bind bus_soc bus_soc_chk i_bus_soc_chk (
    .clk(clk), .rst(rst), .addr(addr), .phys_addr(phys_addr), .irq_flags(irq_flags),
    .irqb(irqb), .txd(txd), .tx_state(i_uart_tx.state), .fifo_push(fifo_push),
    .fifo_full(fifo_full), .fifo_wr_ptr(i_uart_tx_fifo.wr_ptr)
);

/* sim/bus_soc_tb.sv */
`timescale 1ns/1ns

module bus_soc_tb
    import soc_pkg::*;
();

    logic               clk;
    logic               rst;
    logic [15:0]        addr;
    logic               rw;
    logic               bus_valid;
    logic [7:0]         data_in;
    logic [7:0]         data_out;
    logic [phys_aw-1:0] phys_addr;
    logic               button_n;
    logic [7:0]         sw;
    logic [7:0]         led;
    logic               txd;
    logic               irqb;
    logic [31:0]        rng_state = 32'hd0fa4299;
    logic [7:0]         exp_q [$];   // bytes the FIFO accepted, in order
    logic [7:0]         page_model [16];
    logic [7:0]         tx_bytes [13];
    logic [7:0]         button_flag = 8'(1 << irq_button_bit);
    logic [7:0]         uart_flag = 8'(1 << irq_uart_bit);
    int                 mismatches = 0;
    int                 timeouts = 0;

    bus_soc i_bus_soc (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] want, input string what);
        assert (got === want) else begin
            mismatches++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    // bus tasks start and end 2 ns after a rising edge
    task automatic write_byte(input logic [15:0] a, input logic [7:0] d);
        addr = a;
        rw = 1'b0;
        data_in = d;
        bus_valid = 1'b1;
        @(posedge clk);
        #2;
        bus_valid = 1'b0;
        rw = 1'b1;
    endtask

    task automatic read_reg(input logic [15:0] a, output logic [7:0] d);
        addr = a;
        rw = 1'b1;
        bus_valid = 1'b1;
        @(negedge clk);
        d = data_out;   // combinational read data
        @(posedge clk);
        #2;
        bus_valid = 1'b0;
    endtask

    task automatic expect_read(input logic [15:0] a, input logic [7:0] want, input string what);
        logic [7:0] d;
        read_reg(a, d);
        check_value(32'(d), 32'(want), what);
    endtask

    task automatic poll_reg(input logic [15:0] a, input logic [7:0] mask,
                            input logic [7:0] value, input string what);
        logic [7:0] d;
        int n;
        n = 0;
        do begin
            read_reg(a, d);
            n++;
        end while ((d & mask) != value && n < 500);
        if ((d & mask) != value) begin
            timeouts++;
            $display("Timeout while waiting for %s", what);
        end
    endtask

    // start bit found at its first cycle, then sampled at bit centres
    task automatic receive_frames(input int n);
        logic [9:0] frame;
        logic [7:0] want;
        int c;
        for (int f = 0; f < n; f++) begin
            c = 0;
            do begin
                @(negedge clk);
                c++;
            end while (txd && c < 2000);
            if (txd) begin
                timeouts++;
                $display("Timeout while waiting for the start bit of frame %0d", f);
                return;
            end
            repeat (clks_per_bit / 2) @(negedge clk);
            for (int b = 0; b < 10; b++) begin
                if (b > 0) repeat (clks_per_bit) @(negedge clk);
                frame[b] = txd;
            end
            want = exp_q.pop_front();
            check_value(32'(frame), 32'({1'b1, want, 1'b0}), "UART frame");   // 8N1, lsb first
        end
    endtask

    initial begin
        logic [15:0] a;
        rst = 1'b1;
        addr = 16'h0000;
        rw = 1'b1;
        bus_valid = 1'b0;
        data_in = 8'h00;
        button_n = 1'b1;
        sw = 8'h00;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        check_value(32'({txd, irqb, led}), 32'({1'b1, 1'b1, 8'h00}), "txd, irqb and led");
        expect_read(uart_stat_addr, 8'h04, "status after reset");   // empty, idle

        for (int i = 0; i < 16; i++) begin
            page_model[i] = 8'(next_random());
            write_byte(mm_base_addr + 16'(i), page_model[i]);
        end
        write_byte(mm_en_addr, 8'h01);
        for (int i = 0; i < 32; i++) begin
            if (i < 16) expect_read(mm_base_addr + 16'(i), page_model[i], "page register");
            if (i == 16) write_byte(mm_en_addr, 8'h00);
            a = 16'(next_random());
            addr = a;
            @(negedge clk);
            check_value(32'(phys_addr), (i < 16) ? {12'h0, page_model[a[15:12]], a[11:0]}
                        : {16'h0, a}, "phys_addr");
            @(posedge clk);
            #2;
        end

        a = 16'(next_random());
        write_byte(board_addr, a[7:0]);
        check_value(32'(led), 32'(a[7:0]), "led");
        sw = 8'(next_random());
        expect_read(board_addr, sw, "switches");

        fork
            for (int i = 0; i < 6; i++) begin
                a = 16'(next_random());
                exp_q.push_back(a[7:0]);
                write_byte(uart_data_addr, a[7:0]);
            end
            receive_frames(6);
        join
        @(posedge clk);
        #2;

        poll_reg(uart_stat_addr, 8'h02, 8'h00, "the serializer to go idle");
        for (int i = 0; i < 13; i++) begin
            tx_bytes[i] = 8'(next_random());
            if (i <= fifo_depth) exp_q.push_back(tx_bytes[i]);   // one shifting, rest queued
        end
        fork
            begin
                write_byte(uart_data_addr, tx_bytes[0]);
                poll_reg(uart_stat_addr, 8'h02, 8'h02, "the serializer to start");
                for (int i = 1; i < 13; i++) begin
                    write_byte(uart_data_addr, tx_bytes[i]);
                end
                expect_read(uart_stat_addr, 8'h03, "status with a full FIFO");
            end
            receive_frames(fifo_depth + 1);
        join
        @(posedge clk);
        #2;
        expect_read(uart_stat_addr, 8'h06, "status in the last stop bit");   // nothing left

        poll_reg(uart_stat_addr, 8'h02, 8'h00, "the serializer to go idle");
        write_byte(irq_addr, 8'h00);
        check_value(32'(irqb), 32'd1, "irqb with no flags");
        write_byte(uart_data_addr, 8'(next_random()));
        poll_reg(irq_addr, uart_flag, uart_flag, "the UART interrupt flag");
        button_n = 1'b0;
        @(posedge clk);
        #2;
        button_n = 1'b1;
        expect_read(irq_addr, uart_flag | button_flag, "flags with both sources");
        check_value(32'(irqb), 32'd0, "irqb with flags set");
        write_byte(irq_addr, ~button_flag);
        expect_read(irq_addr, uart_flag, "flags after clearing the button");
        check_value(32'(irqb), 32'd0, "irqb with the UART flag left");
        write_byte(irq_addr, ~uart_flag);
        expect_read(irq_addr, 8'h00, "flags after clearing the UART");
        check_value(32'(irqb), 32'd1, "irqb after clearing");

        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end
        else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* source/addr_decode.sv */
`timescale 1ns/1ns

module addr_decode
    import soc_pkg::*;
(
    input  logic [15:0] addr,
    output dev_sel_t    dev
);

    logic page_hit;

    assign page_hit = (addr[15:4] == mm_base_addr[15:4]);   // 7FE0..7FEF

    always_comb begin
        dev = dev_none;
        if (addr == uart_data_addr) begin
            dev = dev_uart_data;
        end
        else if (addr == uart_stat_addr) begin
            dev = dev_uart_stat;
        end
        else if (addr == irq_addr) begin
            dev = dev_irq;
        end
        else if (addr == board_addr) begin
            dev = dev_board;
        end
        else if (addr == mm_en_addr) begin
            dev = dev_mm_en;
        end
        else if (page_hit) begin
            dev = dev_mm_page;
        end
    end

endmodule

/* source/bus_soc.sv */
`timescale 1ns/1ns

module bus_soc
    import soc_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [15:0]        addr,
    input  logic               rw,
    input  logic               bus_valid,
    input  logic [7:0]         data_in,
    output logic [7:0]         data_out,
    output logic [phys_aw-1:0] phys_addr,
    input  logic               button_n,
    input  logic [7:0]         sw,
    output logic [7:0]         led,
    output logic               txd,
    output logic               irqb
);

    dev_sel_t   dev;
    logic       we;
    logic [7:0] mm_rd_data;
    logic [7:0] irq_flags;
    logic [7:0] uart_status;
    logic [7:0] fifo_data;
    logic       fifo_push;
    logic       fifo_pop;
    logic       fifo_full;
    logic       fifo_empty;
    logic       tx_busy;
    logic       tx_done;
    logic       uart_irq;

    assign we = bus_valid && !rw;   // rw high = read
    assign fifo_push = we && (dev == dev_uart_data);
    assign uart_irq = tx_done && fifo_empty;   // queue drained
    assign uart_status = {5'b0, fifo_empty, tx_busy, fifo_full};

    addr_decode i_addr_decode (.addr(addr), .dev(dev));

    memory_mapper i_memory_mapper (
        .clk(clk), .rst(rst), .dev(dev), .we(we), .addr(addr),
        .data_in(data_in), .rd_data(mm_rd_data), .phys_addr(phys_addr)
    );

    irq_ctrl i_irq_ctrl (
        .clk(clk), .rst(rst), .we(we && dev == dev_irq), .data_in(data_in),
        .button_n(button_n), .uart_irq(uart_irq), .flags(irq_flags), .irqb(irqb)
    );

    uart_tx_fifo i_uart_tx_fifo (
        .clk(clk), .rst(rst), .push(fifo_push), .push_data(data_in), .pop(fifo_pop),
        .pop_data(fifo_data), .full(fifo_full), .empty(fifo_empty)
    );

    uart_tx i_uart_tx (
        .clk(clk), .rst(rst), .fifo_empty(fifo_empty), .fifo_data(fifo_data),
        .pop(fifo_pop), .txd(txd), .busy(tx_busy), .done(tx_done)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            led <= 8'h00;
        end
        else if (we && dev == dev_board) begin
            led <= data_in;
        end
    end

    always_comb begin
        case (dev)
            dev_uart_stat: data_out = uart_status;
            dev_irq:       data_out = irq_flags;
            dev_board:     data_out = sw;
            dev_mm_page,
            dev_mm_en:     data_out = mm_rd_data;
            default:       data_out = 8'h00;   // also uart data and unmapped
        endcase
    end

endmodule

/* source/irq_ctrl.sv */
`timescale 1ns/1ns

module irq_ctrl
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       we,
    input  logic [7:0] data_in,
    input  logic       button_n,
    input  logic       uart_irq,
    output logic [7:0] flags,
    output logic       irqb
);

    logic [7:0] set_v;

    always_comb begin
        set_v = 8'h00;
        set_v[irq_button_bit] = ~button_n;   // level, active low
        set_v[irq_uart_bit] = uart_irq;
    end

    // a set at the same edge as a clear keeps its bit
    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= 8'h00;
        end
        else if (we) begin
            flags <= (flags & data_in) | set_v;
        end
        else begin
            flags <= flags | set_v;
        end
    end

    assign irqb = ~|flags;

endmodule

/* source/memory_mapper.sv */
`timescale 1ns/1ns

module memory_mapper
    import soc_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  dev_sel_t           dev,
    input  logic               we,
    input  logic [15:0]        addr,
    input  logic [7:0]         data_in,
    output logic [7:0]         rd_data,
    output logic [phys_aw-1:0] phys_addr
);

    logic [7:0] pages [16];
    logic       en;

    always_ff @(posedge clk) begin
        if (rst) begin
            en <= 1'b0;
            for (int i = 0; i < 16; i++) begin
                pages[i] <= 8'(i);   // identity map
            end
        end
        else if (we) begin
            if (dev == dev_mm_page) begin
                pages[addr[3:0]] <= data_in;
            end
            if (dev == dev_mm_en) begin
                en <= data_in[0];
            end
        end
    end

    always_comb begin
        case (dev)
            dev_mm_page: rd_data = pages[addr[3:0]];
            dev_mm_en:   rd_data = {7'b0, en};
            default:     rd_data = 8'h00;
        endcase
    end

    // top nibble picks the page, offset passes through
    always_comb begin
        if (en) begin
            phys_addr = {pages[addr[15:12]], addr[11:0]};
        end
        else begin
            phys_addr = {{(phys_aw - 16){1'b0}}, addr};
        end
    end

endmodule

/* source/soc_pkg.sv */
package soc_pkg;

    localparam int clks_per_bit = 4;   // short bit time for simulation
    localparam int baud_w = $clog2(clks_per_bit);
    localparam int fifo_depth = 8;
    localparam int fifo_aw = 3;
    localparam int phys_aw = 20;

    // io window
    localparam logic [15:0] uart_data_addr = 16'h7FF0;
    localparam logic [15:0] uart_stat_addr = 16'h7FF1;   // read only
    localparam logic [15:0] irq_addr = 16'h7FF4;
    localparam logic [15:0] board_addr = 16'h7FF5;
    localparam logic [15:0] mm_en_addr = 16'h7FF8;
    localparam logic [15:0] mm_base_addr = 16'h7FE0;    // 16 page regs

    localparam int irq_button_bit = 0;
    localparam int irq_uart_bit = 1;

    typedef enum logic [2:0] {
        dev_none,
        dev_uart_data,
        dev_uart_stat,
        dev_irq,
        dev_board,
        dev_mm_page,
        dev_mm_en
    } dev_sel_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

endpackage

/* source/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       fifo_empty,
    input  logic [7:0] fifo_data,
    output logic       pop,
    output logic       txd,
    output logic       busy,
    output logic       done
);

    tx_state_t         state;
    logic [baud_w-1:0] cnt;
    logic [2:0]        bit_idx;
    logic [7:0]        shreg;
    logic              baud_end;

    assign baud_end = (cnt == baud_w'(clks_per_bit - 1));
    assign done = (state == tx_stop) && baud_end;
    // fetch from idle, or straight out of the stop bit for back to back frames
    assign pop = ((state == tx_idle) || done) && !fifo_empty;
    assign busy = (state != tx_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= tx_idle;
            cnt <= '0;
            bit_idx <= '0;
        end
        else begin
            cnt <= (baud_end || state == tx_idle) ? '0 : cnt + 1'b1;
            case (state)
                tx_idle: if (pop) state <= tx_start;
                tx_start: begin
                    if (baud_end) begin
                        state <= tx_data;
                        bit_idx <= '0;
                    end
                end
                tx_data: begin
                    if (baud_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= tx_stop;
                    end
                end
                tx_stop: if (baud_end) state <= pop ? tx_start : tx_idle;
                default: state <= tx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            shreg <= fifo_data;
        end
        else if (state == tx_data && baud_end) begin
            shreg <= shreg >> 1;   // lsb first
        end
    end

    assign txd = (state == tx_start) ? 1'b0 : (state == tx_data) ? shreg[0] : 1'b1;

endmodule

/* source/uart_tx_fifo.sv */
`timescale 1ns/1ns

module uart_tx_fifo
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] pop_data,
    output logic       full,
    output logic       empty
);

    logic [7:0]         mem [fifo_depth];
    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    logic [fifo_aw:0]   count;
    logic               push_ok;
    logic               pop_ok;

    assign full = (count == (fifo_aw + 1)'(fifo_depth));
    assign empty = (count == '0);
    assign push_ok = push && !full;   // dropped when full
    assign pop_ok = pop && !empty;

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign pop_data = mem[rd_ptr];   // show-ahead

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{fifo_aw{1'b0}}, push_ok} - {{fifo_aw{1'b0}}, pop_ok};
        end
    end

endmodule
